// ==== Makefile ====
TOP = dpc_detector_tb
LOG = sim.log

.PHONY: run clean

run:
	verilator --binary --timing --assert --top-module $(TOP) -f dpc_detector.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dpc_detector.f ====
src/dpc_pkg.sv
src/raster_sequencer.sv
src/k_line_buffer.sv
src/k_window.sv
src/neighbor_median.sv
src/manual_list_matcher.sv
src/defect_recorder.sv
src/dpc_detector.sv
testbench/dpc_detector_checker.sv
testbench/dpc_detector_tb.sv

// ==== src/defect_recorder.sv ====
// defect classification and list
`timescale 1ns/100ps

module defect_recorder
    import dpc_pkg::*;
(
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       frame_start,
    input  center_tag_t                center_in,
    input  logic                       manual_hit,
    input  logic [K_WIDTH-1:0]         median,
    input  logic                       has_median,
    input  k_sample_t                  center_k,
    input  logic [K_WIDTH-1:0]         threshold,
    input  logic [LIST_ADDR_WIDTH-1:0] read_addr,
    output logic                       bp_valid,
    output defect_entry_t              bp_entry,
    output logic [LIST_ADDR_WIDTH:0]   bp_count,
    output defect_entry_t              read_data,
    output logic                       frame_done
);

    defect_entry_t      list_mem [LIST_DEPTH];
    defect_kind_e       kind;
    defect_entry_t      entry;
    logic [K_WIDTH-1:0] diff;
    logic               defect;
    logic               store;
    logic               last_tag;

    // =========================================================================
    // classification
    // =========================================================================
    assign diff = (center_k.k > median) ? center_k.k - median : median - center_k.k;

    always_comb begin
        if (manual_hit) begin
            kind = DEFECT_MANUAL;
        end else if (center_k.k == '0) begin
            kind = DEFECT_DEAD;
        end else if (has_median && diff > threshold) begin
            kind = DEFECT_BLIND;
        end else begin
            kind = DEFECT_NONE;
        end
    end

    assign entry    = '{kind: kind, pos: center_in.pos};
    assign defect   = center_in.valid && kind != DEFECT_NONE;
    assign store    = defect && bp_count < (LIST_ADDR_WIDTH + 1)'(LIST_DEPTH);   // list full
    assign last_tag = center_in.valid &&
                      center_in.pos.x == COORD_WIDTH'(FRAME_WIDTH - 1) &&
                      center_in.pos.y == COORD_WIDTH'(FRAME_HEIGHT - 1);

    // =========================================================================
    // strobe, count and list memory
    // =========================================================================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bp_valid   <= 1'b0;
            frame_done <= 1'b0;
            bp_count   <= '0;
        end else begin
            bp_valid   <= defect;
            frame_done <= last_tag;
            if (frame_start) begin
                bp_count <= '0;
            end else if (store) begin
                bp_count <= bp_count + 1'b1;   // stops at LIST_DEPTH
            end
        end
    end

    always_ff @(posedge aclk) begin
        bp_entry <= entry;
        if (store) begin
            list_mem[bp_count[LIST_ADDR_WIDTH-1:0]] <= entry;
        end
        read_data <= (read_addr < bp_count) ? list_mem[read_addr] : '0;   // stale slots read 0
    end

endmodule

// ==== src/dpc_detector.sv ====
// k based bad pixel detector top
`timescale 1ns/100ps

module dpc_detector
    import dpc_pkg::*;
(
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         k_valid,
    input  logic [K_WIDTH-1:0]           k_data,
    input  logic                         sof,
    input  logic [K_WIDTH-1:0]           threshold,
    input  logic                         manual_wen,
    input  logic [MANUAL_ADDR_WIDTH-1:0] manual_waddr,
    input  pixel_pos_t                   manual_wdata,
    input  logic [MANUAL_ADDR_WIDTH:0]   manual_count,
    input  logic [LIST_ADDR_WIDTH-1:0]   read_addr,
    output logic                         busy,
    output logic                         bp_valid,
    output defect_entry_t                bp_entry,
    output logic [LIST_ADDR_WIDTH:0]     bp_count,
    output defect_entry_t                read_data,
    output logic                         frame_done
);

    k_sample_t          sample;
    center_tag_t        center_tag;
    logic               frame_start;
    neighbors_t         neighbors;
    k_sample_t          win_center_k;
    logic [K_WIDTH-1:0] median;
    logic               has_median;
    k_sample_t          med_center_k;
    logic               manual_hit;
    center_tag_t        rec_center;

    raster_sequencer u_sequencer (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .k_valid     (k_valid),
        .k_data      (k_data),
        .sof         (sof),
        .sample      (sample),
        .center      (center_tag),
        .frame_start (frame_start),
        .busy        (busy)
    );

    k_window u_window (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .sample    (sample),
        .center_in (center_tag),
        .neighbors (neighbors),
        .center_k  (win_center_k)
    );

    // median path and manual matcher run side by side off the same tag
    neighbor_median u_median (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .neighbors    (neighbors),
        .center_k     (win_center_k),
        .median       (median),
        .has_median   (has_median),
        .center_k_out (med_center_k)
    );

    manual_list_matcher u_matcher (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .frame_start (frame_start),
        .center_in   (center_tag),
        .wen         (manual_wen),
        .waddr       (manual_waddr),
        .wdata       (manual_wdata),
        .count       (manual_count),
        .manual_hit  (manual_hit),
        .center_out  (rec_center)
    );

    defect_recorder u_recorder (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .frame_start (frame_start),
        .center_in   (rec_center),
        .manual_hit  (manual_hit),
        .median      (median),
        .has_median  (has_median),
        .center_k    (med_center_k),
        .threshold   (threshold),
        .read_addr   (read_addr),
        .bp_valid    (bp_valid),
        .bp_entry    (bp_entry),
        .bp_count    (bp_count),
        .read_data   (read_data),
        .frame_done  (frame_done)
    );

endmodule

// ==== src/dpc_pkg.sv ====
// bad pixel detector shared types and sizes
package dpc_pkg;

    localparam int K_WIDTH           = 16;
    localparam int COORD_WIDTH       = 10;
    localparam int FRAME_WIDTH       = 16;
    localparam int FRAME_HEIGHT      = 8;
    localparam int MANUAL_MAX        = 16;
    localparam int MANUAL_ADDR_WIDTH = 4;
    localparam int LIST_DEPTH        = 32;
    localparam int LIST_ADDR_WIDTH   = 5;
    localparam int MEDIAN_LATENCY    = 3;
    localparam int WINDOW_STAGES     = 2;   // column registers up to the window center

    // sample register plus one row plus the window columns
    localparam int CENTER_DELAY = FRAME_WIDTH + WINDOW_STAGES + 1;

    // invalid beats after the last pixel until its report and frame_done are out
    localparam int DRAIN_CYCLES    = FRAME_WIDTH + WINDOW_STAGES + MEDIAN_LATENCY + 2;
    localparam int DRAIN_CNT_WIDTH = $clog2(DRAIN_CYCLES);

    typedef struct packed {
        logic [COORD_WIDTH-1:0] x;
        logic [COORD_WIDTH-1:0] y;
    } pixel_pos_t;

    typedef struct packed {
        logic               invalid;   // dead or outside the frame
        logic [K_WIDTH-1:0] k;
    } k_sample_t;

    localparam k_sample_t NO_SAMPLE = '{invalid: 1'b1, k: '0};

    typedef struct packed {
        logic       valid;
        pixel_pos_t pos;
    } center_tag_t;

    // 0..7 = top left, top, top right, left, right, bottom left, bottom, bottom right
    typedef k_sample_t [7:0] neighbors_t;

    typedef enum logic [1:0] {
        DEFECT_NONE,
        DEFECT_DEAD,
        DEFECT_BLIND,
        DEFECT_MANUAL
    } defect_kind_e;

    typedef struct packed {
        defect_kind_e kind;
        pixel_pos_t   pos;
    } defect_entry_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_STREAM,
        SEQ_DRAIN
    } seq_state_e;

endpackage

// ==== src/k_line_buffer.sv ====
// one row delay for k samples
`timescale 1ns/100ps

module k_line_buffer
    import dpc_pkg::*;
(
    input  logic      aclk,
    input  k_sample_t in_sample,
    output k_sample_t out_sample
);

    k_sample_t mem [FRAME_WIDTH];

    // shifts every cycle, drain beats push the tail through
    always_ff @(posedge aclk) begin
        mem[0] <= in_sample;
        for (int i = 1; i < FRAME_WIDTH; i++) begin
            mem[i] <= mem[i-1];
        end
    end

    assign out_sample = mem[FRAME_WIDTH-1];

endmodule

// ==== src/k_window.sv ====
// 3x3 k window with frame edge masking
`timescale 1ns/100ps

module k_window
    import dpc_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  k_sample_t   sample,
    input  center_tag_t center_in,
    output neighbors_t  neighbors,
    output k_sample_t   center_k
);

    k_sample_t row_mid;
    k_sample_t row_top;
    k_sample_t rows [3];
    k_sample_t win  [3][3];   // [row][col], col 2 is the newest
    logic      top_edge;
    logic      bottom_edge;
    logic      left_edge;
    logic      right_edge;

    k_line_buffer u_lb_mid (
        .aclk       (aclk),
        .in_sample  (sample),
        .out_sample (row_mid)
    );

    k_line_buffer u_lb_top (
        .aclk       (aclk),
        .in_sample  (row_mid),
        .out_sample (row_top)
    );

    assign rows[0] = row_top;
    assign rows[1] = row_mid;
    assign rows[2] = sample;

    always_ff @(posedge aclk) begin
        for (int r = 0; r < 3; r++) begin
            if (!aresetn) begin
                for (int c = 0; c < 3; c++) begin
                    win[r][c].invalid <= 1'b1;
                end
            end else begin
                win[r][2] <= rows[r];
                win[r][1] <= win[r][2];
                win[r][0] <= win[r][1];
            end
        end
    end

    // row wrap and the rows around the frame are cut off here
    assign top_edge    = center_in.pos.y == '0;
    assign bottom_edge = center_in.pos.y == COORD_WIDTH'(FRAME_HEIGHT - 1);
    assign left_edge   = center_in.pos.x == '0;
    assign right_edge  = center_in.pos.x == COORD_WIDTH'(FRAME_WIDTH - 1);

    assign neighbors[0] = (top_edge || left_edge)     ? NO_SAMPLE : win[0][0];
    assign neighbors[1] = top_edge                    ? NO_SAMPLE : win[0][1];
    assign neighbors[2] = (top_edge || right_edge)    ? NO_SAMPLE : win[0][2];
    assign neighbors[3] = left_edge                   ? NO_SAMPLE : win[1][0];
    assign neighbors[4] = right_edge                  ? NO_SAMPLE : win[1][2];
    assign neighbors[5] = (bottom_edge || left_edge)  ? NO_SAMPLE : win[2][0];
    assign neighbors[6] = bottom_edge                 ? NO_SAMPLE : win[2][1];
    assign neighbors[7] = (bottom_edge || right_edge) ? NO_SAMPLE : win[2][2];

    assign center_k = win[1][1];

endmodule

// ==== src/manual_list_matcher.sv ====
// manual bad pixel list matcher
`timescale 1ns/100ps

module manual_list_matcher
    import dpc_pkg::*;
(
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         frame_start,
    input  center_tag_t                  center_in,
    input  logic                         wen,
    input  logic [MANUAL_ADDR_WIDTH-1:0] waddr,
    input  pixel_pos_t                   wdata,
    input  logic [MANUAL_ADDR_WIDTH:0]   count,
    output logic                         manual_hit,
    output center_tag_t                  center_out
);

    pixel_pos_t                 entries [MANUAL_MAX];
    logic [MANUAL_ADDR_WIDTH:0] ptr;
    logic                       hit;
    logic                       hit_pipe [MEDIAN_LATENCY];
    center_tag_t                tag_pipe [MEDIAN_LATENCY];

    always_ff @(posedge aclk) begin
        if (wen) begin
            entries[waddr] <= wdata;
        end
    end

    // entries are in raster order, so only the next one can match
    assign hit = center_in.valid && ptr < count &&
                 center_in.pos == entries[ptr[MANUAL_ADDR_WIDTH-1:0]];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ptr <= '0;
        end else if (frame_start) begin
            ptr <= '0;
        end else if (hit) begin
            ptr <= ptr + 1'b1;
        end
    end

    // match the median path delay
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < MEDIAN_LATENCY; i++) begin
                hit_pipe[i]       <= 1'b0;
                tag_pipe[i].valid <= 1'b0;
            end
        end else begin
            hit_pipe[0] <= hit;
            tag_pipe[0] <= center_in;
            for (int i = 1; i < MEDIAN_LATENCY; i++) begin
                hit_pipe[i] <= hit_pipe[i-1];
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign manual_hit = hit_pipe[MEDIAN_LATENCY-1];
    assign center_out = tag_pipe[MEDIAN_LATENCY-1];

endmodule

// ==== src/neighbor_median.sv ====
// lower median of the valid neighbors
`timescale 1ns/100ps

module neighbor_median
    import dpc_pkg::*;
(
    input  logic               aclk,
    input  logic               aresetn,
    input  neighbors_t         neighbors,
    input  k_sample_t          center_k,
    output logic [K_WIDTH-1:0] median,
    output logic               has_median,
    output k_sample_t          center_k_out
);

    logic [K_WIDTH-1:0] packed_k [8];
    logic [3:0]         n_valid;
    logic [K_WIDTH-1:0] s1_k [8];
    logic [3:0]         s1_n;
    k_sample_t          s1_center;
    logic [2:0]         rank [8];
    logic [K_WIDTH-1:0] s2_k [8];
    logic [2:0]         s2_rank [8];
    logic [2:0]         s2_sel;
    logic               s2_has;
    k_sample_t          s2_center;
    logic [K_WIDTH-1:0] pick;

    // =========================================================================
    // stage 1, compaction
    // =========================================================================
    always_comb begin
        n_valid = '0;
        for (int i = 0; i < 8; i++) begin
            packed_k[i] = '1;   // padding sorts after every valid value
        end
        for (int i = 0; i < 8; i++) begin
            if (!neighbors[i].invalid) begin
                packed_k[n_valid[2:0]] = neighbors[i].k;
                n_valid = n_valid + 4'd1;
            end
        end
    end

    // =========================================================================
    // stage 2 ranks, stage 3 select
    // =========================================================================
    // ties broken by slot so every rank is unique
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            rank[i] = '0;
            for (int j = 0; j < 8; j++) begin
                if (s1_k[j] < s1_k[i] || (s1_k[j] == s1_k[i] && j < i)) begin
                    rank[i] = rank[i] + 3'd1;
                end
            end
        end
    end

    always_comb begin
        pick = s2_k[0];
        for (int i = 0; i < 8; i++) begin
            if (s2_rank[i] == s2_sel) begin
                pick = s2_k[i];
            end
        end
    end

    always_ff @(posedge aclk) begin
        s1_k         <= packed_k;
        s1_n         <= n_valid;
        s1_center    <= center_k;
        s2_k         <= s1_k;
        s2_rank      <= rank;
        s2_sel       <= 3'((s1_n - 4'd1) >> 1);   // index (n-1)/2
        s2_center    <= s1_center;
        median       <= pick;
        center_k_out <= s2_center;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s2_has     <= 1'b0;
            has_median <= 1'b0;
        end else begin
            s2_has     <= s1_n != '0;
            has_median <= s2_has;
        end
    end

endmodule

// ==== src/raster_sequencer.sv ====
// frame sequencer and center tag
`timescale 1ns/100ps

module raster_sequencer
    import dpc_pkg::*;
(
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               k_valid,
    input  logic [K_WIDTH-1:0] k_data,
    input  logic               sof,
    output k_sample_t          sample,
    output center_tag_t        center,
    output logic               frame_start,
    output logic               busy
);

    seq_state_e                 state;
    logic [COORD_WIDTH-1:0]     x;
    logic [COORD_WIDTH-1:0]     y;
    logic [DRAIN_CNT_WIDTH-1:0] drain_cnt;
    logic                       accept;
    logic                       last_pixel;
    center_tag_t                tag_pipe [CENTER_DELAY];

    // sof only opens a frame from idle
    assign accept     = k_valid && ((state == SEQ_IDLE && sof) || state == SEQ_STREAM);
    assign last_pixel = x == COORD_WIDTH'(FRAME_WIDTH - 1) && y == COORD_WIDTH'(FRAME_HEIGHT - 1);
    assign busy       = state != SEQ_IDLE;   // high through the frame_done cycle

    // =========================================================================
    // state machine and raster counters
    // =========================================================================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state       <= SEQ_IDLE;
            x           <= '0;
            y           <= '0;
            drain_cnt   <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= accept && state == SEQ_IDLE;
            if (state == SEQ_DRAIN) begin
                drain_cnt <= drain_cnt + 1'b1;
                if (drain_cnt == DRAIN_CNT_WIDTH'(DRAIN_CYCLES - 1)) begin
                    drain_cnt <= '0;
                    state     <= SEQ_IDLE;
                end
            end else if (accept) begin
                state <= last_pixel ? SEQ_DRAIN : SEQ_STREAM;
                if (x == COORD_WIDTH'(FRAME_WIDTH - 1)) begin
                    x <= '0;
                    y <= last_pixel ? '0 : y + 1'b1;   // wrap for the next frame
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

    // zero k marks the sample dead, drain feeds empty samples
    always_ff @(posedge aclk) begin
        sample <= accept ? '{invalid: k_data == '0, k: k_data} : NO_SAMPLE;
    end

    // =========================================================================
    // center tag delay line
    // =========================================================================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < CENTER_DELAY; i++) begin
                tag_pipe[i].valid <= 1'b0;
            end
        end else begin
            tag_pipe[0] <= '{valid: accept, pos: '{x: x, y: y}};
            for (int i = 1; i < CENTER_DELAY; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign center = tag_pipe[CENTER_DELAY-1];

endmodule

// ==== testbench/dpc_detector_checker.sv ====
// detector protocol assertions
`timescale 1ns/100ps

module dpc_detector_checker
    import dpc_pkg::*;
(
    input logic                     aclk,
    input logic                     aresetn,
    input logic                     busy,
    input logic                     bp_valid,
    input logic                     frame_done,
    input logic [LIST_ADDR_WIDTH:0] bp_count
);

    // strobes only while a frame is in flight
    a_strobe_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        bp_valid |-> busy)
        else $error("bp_valid while not busy");

    a_count_max: assert property (@(posedge aclk) disable iff (!aresetn)
        bp_count <= (LIST_ADDR_WIDTH + 1)'(LIST_DEPTH))
        else $error("bp_count above list depth");

    a_done_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        frame_done |=> !frame_done)
        else $error("frame_done longer than one cycle");

    // first cycle out of reset
    a_reset_state: assert property (@(posedge aclk)
        $rose(aresetn) |-> !busy && !frame_done && !bp_valid && bp_count == '0)
        else $error("outputs not idle after reset");

endmodule

bind dpc_detector dpc_detector_checker u_checker (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .busy       (busy),
    .bp_valid   (bp_valid),
    .frame_done (frame_done),
    .bp_count   (bp_count)
);

// ==== testbench/dpc_detector_tb.sv ====
// bad pixel detector testbench
`timescale 1ns/100ps

module dpc_detector_tb
    import dpc_pkg::*;
();

    logic                         aclk;
    logic                         aresetn;
    logic                         k_valid;
    logic [K_WIDTH-1:0]           k_data;
    logic                         sof;
    logic [K_WIDTH-1:0]           threshold;
    logic                         manual_wen;
    logic [MANUAL_ADDR_WIDTH-1:0] manual_waddr;
    pixel_pos_t                   manual_wdata;
    logic [MANUAL_ADDR_WIDTH:0]   manual_count;
    logic [LIST_ADDR_WIDTH-1:0]   read_addr;
    logic                         busy;
    logic                         bp_valid;
    defect_entry_t                bp_entry;
    logic [LIST_ADDR_WIDTH:0]     bp_count;
    defect_entry_t                read_data;
    logic                         frame_done;

    logic [K_WIDTH-1:0] frame_k [FRAME_HEIGHT][FRAME_WIDTH];
    pixel_pos_t         manual_q [$];
    defect_entry_t      exp_q [$];
    defect_entry_t      got_q [$];
    int                 done_seen;
    int                 errors;
    int                 checks;
    int                 test_errors;
    int                 tests_run;
    string              test_name;

    dpc_detector u_dpc_detector (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // ========================================================================
    // compare tasks and helpers
    // ========================================================================
    task automatic check_entry(input string what, input defect_entry_t exp,
                               input defect_entry_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("FAIL %s %s expected kind %0d at (%0d,%0d) actual kind %0d at (%0d,%0d)",
                     test_name, what, exp.kind, exp.pos.x, exp.pos.y,
                     act.kind, act.pos.x, act.pos.y);
        end
    endtask

    task automatic check_count(input string what, input logic [LIST_ADDR_WIDTH:0] exp,
                               input logic [LIST_ADDR_WIDTH:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("FAIL %s %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_number(input string what, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            test_errors++;
            $display("FAIL %s %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s in test %s", reason, test_name);
        $display("Something failed");
        $finish;
    endtask

    function automatic pixel_pos_t pos_of(input int x, input int y);
        return '{x: COORD_WIDTH'(x), y: COORD_WIDTH'(y)};
    endfunction

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic defect_kind_e classify(input int x, input int y);
        logic [K_WIDTH-1:0] vals [$];
        logic [K_WIDTH-1:0] med;
        int                 nx;
        int                 ny;
        int                 diff;
        foreach (manual_q[i]) begin
            if (manual_q[i] == pos_of(x, y)) return DEFECT_MANUAL;
        end
        if (frame_k[y][x] == '0) return DEFECT_DEAD;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                nx = x + dx;
                ny = y + dy;
                // off-frame and dead neighbors drop out
                if ((dx != 0 || dy != 0) && nx >= 0 && nx < FRAME_WIDTH &&
                    ny >= 0 && ny < FRAME_HEIGHT && frame_k[ny][nx] != '0) begin
                    vals.push_back(frame_k[ny][nx]);
                end
            end
        end
        if (vals.size() == 0) return DEFECT_NONE;
        vals.sort();
        med  = vals[(vals.size() - 1) / 2];   // lower median
        diff = int'(frame_k[y][x]) - int'(med);
        if (diff < 0) diff = -diff;
        return (diff > int'(threshold)) ? DEFECT_BLIND : DEFECT_NONE;
    endfunction

    function automatic void build_expected();
        defect_kind_e kind;
        exp_q.delete();
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) begin
                kind = classify(x, y);
                if (kind != DEFECT_NONE) exp_q.push_back('{kind: kind, pos: pos_of(x, y)});
            end
        end
    endfunction

    function automatic void fill_uniform(input int value);
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) frame_k[y][x] = K_WIDTH'(value);
        end
    endfunction

    function automatic void fill_random(input int base, input int spread, input int dead_odds);
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) begin
                if ($urandom_range(dead_odds - 1) == 0) frame_k[y][x] = '0;
                else frame_k[y][x] = K_WIDTH'(base + int'($urandom_range(spread)));
            end
        end
    endfunction

    // ========================================================================
    // drive and collect
    // ========================================================================
    task automatic step();
        @(negedge aclk);
        if (bp_valid) got_q.push_back(bp_entry);
        if (frame_done) done_seen++;
    endtask

    task automatic load_manual();
        foreach (manual_q[i]) begin
            @(negedge aclk);
            manual_wen   = 1'b1;
            manual_waddr = MANUAL_ADDR_WIDTH'(i);
            manual_wdata = manual_q[i];
        end
        @(negedge aclk);
        manual_wen   = 1'b0;
        manual_count = (MANUAL_ADDR_WIDTH + 1)'(manual_q.size());
    endtask

    task automatic run_frame();
        int waited;
        int limit;
        limit = 2 * (FRAME_WIDTH * FRAME_HEIGHT + DRAIN_CYCLES);
        got_q.delete();
        done_seen = 0;
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) begin
                step();
                k_valid = 1'b1;
                sof     = (x == 0 && y == 0);
                k_data  = frame_k[y][x];
            end
        end
        step();
        k_valid = 1'b0;
        sof     = 1'b0;
        k_data  = '0;
        waited  = 0;
        while (done_seen == 0 && waited < limit) begin
            step();
            waited++;
        end
        if (done_seen == 0) abort_run("frame_done never came after the last pixel");
        waited = 0;
        while (busy && waited < limit) begin   // tail of the drain
            step();
            waited++;
        end
        if (busy) abort_run("busy stayed high after frame_done");
    endtask

    task automatic check_strobes();
        int                       n;
        logic [LIST_ADDR_WIDTH:0] exp_count;
        check_number("strobe count", exp_q.size(), got_q.size());
        n = (exp_q.size() < got_q.size()) ? exp_q.size() : got_q.size();
        for (int i = 0; i < n; i++) check_entry($sformatf("strobe %0d", i), exp_q[i], got_q[i]);
        check_number("frame_done pulses", 1, done_seen);
        exp_count = (LIST_ADDR_WIDTH + 1)'((exp_q.size() > LIST_DEPTH) ? LIST_DEPTH
                                                                         : exp_q.size());
        check_count("bp_count", exp_count, bp_count);
    endtask

    task automatic check_list();
        defect_entry_t exp;
        for (int i = 0; i < LIST_DEPTH; i++) begin
            @(negedge aclk);
            read_addr = LIST_ADDR_WIDTH'(i);
            @(negedge aclk);   // registered read
            if (i < exp_q.size()) exp = exp_q[i];
            else exp = '0;
            check_entry($sformatf("list %0d", i), exp, read_data);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        $display("test %-12s %s", test_name, (test_errors == 0) ? "passed" : "had errors");
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic test_uniform();
        begin_test("uniform");
        check_count("count after reset", '0, bp_count);
        fill_uniform(1000);
        threshold = K_WIDTH'(100);
        manual_q.delete();
        load_manual();
        build_expected();
        run_frame();
        check_strobes();
        check_list();
        end_test();
    endtask

    task automatic test_dead();
        begin_test("dead");
        fill_uniform(1000);
        frame_k[0][0]  = '0;   // corners
        frame_k[0][15] = '0;
        frame_k[7][0]  = '0;
        frame_k[7][15] = '0;
        frame_k[0][6]  = '0;   // edges
        frame_k[4][0]  = '0;
        frame_k[3][15] = '0;
        frame_k[7][9]  = '0;
        frame_k[4][8]  = '0;
        frame_k[1][0]  = '0;   // three of the five neighbors of (1,0) dead
        frame_k[1][1]  = '0;
        build_expected();
        run_frame();
        check_strobes();
        check_list();
        end_test();
    endtask

    task automatic test_blind();
        begin_test("blind");
        fill_uniform(1000);
        threshold      = K_WIDTH'(50);
        frame_k[2][3]  = K_WIDTH'(1051);
        frame_k[5][10] = K_WIDTH'(949);
        frame_k[4][6]  = K_WIDTH'(1050);   // right at the threshold
        build_expected();
        run_frame();
        check_strobes();
        check_list();
        end_test();
    endtask

    task automatic test_manual();
        begin_test("manual");
        fill_uniform(1000);
        frame_k[3][9] = '0;   // listed and dead
        frame_k[5][4] = '0;
        manual_q.delete();
        manual_q.push_back(pos_of(2, 1));
        manual_q.push_back(pos_of(9, 3));
        manual_q.push_back(pos_of(14, 6));
        load_manual();
        build_expected();
        run_frame();
        check_strobes();
        check_list();
        end_test();
    endtask

    task automatic test_saturate();
        begin_test("saturate");
        fill_random(100, 4000, 8);
        threshold = K_WIDTH'(50);
        manual_q.delete();
        load_manual();
        build_expected();
        run_frame();
        check_strobes();
        check_list();
        end_test();
    endtask

    task automatic test_back_to_back();
        begin_test("back2back");
        manual_q.delete();
        manual_q.push_back(pos_of(5, 2));
        manual_q.push_back(pos_of(11, 7));
        load_manual();
        fill_random(1000, 80, 16);
        threshold = K_WIDTH'(50);
        build_expected();
        run_frame();
        check_strobes();
        fill_random(1000, 40, 20);   // next sof as soon as busy drops
        threshold = K_WIDTH'(30);
        build_expected();
        run_frame();
        check_strobes();
        check_list();
        end_test();
    endtask

    initial begin
        void'($urandom(32'h48fc_8c99));
        aresetn      = 1'b0;
        k_valid      = 1'b0;
        k_data       = '0;
        sof          = 1'b0;
        threshold    = '0;
        manual_wen   = 1'b0;
        manual_waddr = '0;
        manual_wdata = '0;
        manual_count = '0;
        read_addr    = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        test_name    = "reset";
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        test_uniform();
        test_dead();
        test_blind();
        test_manual();
        test_saturate();
        test_back_to_back();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
